// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= core_top.f
TB_TOP    ?= tb_core_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: core_top.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/hazard_if.sv
source/pipe_stage_reg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/hazard_unit.sv
source/core_top.sv
sim/tb_core_top.sv

// File: sim/tb_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core_top
  import isa_pkg::*;
();

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 2;
  localparam int    DRAIN_CYCLES = 12;
  localparam int    MEM_WORDS    = 256;
  localparam int    MODEL_STEPS  = 1000;
  localparam int    RAND_PROGS   = 10;
  localparam int    RAND_OPS     = 20;
  localparam word_t RESET_PC     = 32'h0000_0040;
  localparam int    IMEM_BASE    = int'(RESET_PC >> 2);
  localparam word_t LCG_SEED     = 32'hdf04_3036;
  // alu chain, load use, stores, branches, r0, then the random programs.
  localparam int    TOTAL_INSTR  = 11 + 8 + 10 + 13 + 8 + RAND_PROGS * (7 + RAND_OPS + 1);
  localparam int    WATCHDOG_NS  = TOTAL_INSTR * 8 * CLK_PERIOD;

  logic     clk;
  logic     arst_n;
  word_t    imem_addr;
  word_t    imem_rdata;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  logic     dmem_we;
  word_t    dmem_rdata;
  logic     wb_valid;
  reg_idx_t wb_dest;
  word_t    wb_data;

  word_t    imem [MEM_WORDS];
  word_t    dmem [MEM_WORDS];
  word_t    mdl_mem [MEM_WORDS];
  word_t    mdl_regs [NUM_REGS];
  word_t    prog [$];
  reg_idx_t exp_dest [$];
  word_t    exp_wdata [$];
  word_t    exp_saddr [$];
  word_t    exp_sdata [$];
  word_t    lcg_state;
  logic     armed;
  int       errors;
  int       checks;
  int       tests;

  core_top #(.RESET_PC(RESET_PC)) UUT (
    .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata), .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
  );

  // fetches beyond the array return a no-op.
  assign imem_rdata = (imem_addr < 32'd1024) ? imem[imem_addr[9:2]] : '0;
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
  endfunction

  always @(posedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= fill_word(i); // data memory is refilled while reset is held.
      end
    end else if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t enc_r(input funct_e f, input reg_idx_t rd, input reg_idx_t rs,
                                  input reg_idx_t rt);
    return {R_TYPE, rs, rt, rd, 5'd0, f};
  endfunction

  function automatic word_t enc_i(input opcode_e op, input reg_idx_t rt, input reg_idx_t rs,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(input word_t addr);
    return {J, addr[27:2]};
  endfunction

  function automatic word_t instr_addr(input int idx);
    return RESET_PC + word_t'(idx * 4);
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  task automatic emit_halt();
    emit(enc_j(instr_addr(prog.size()))); // a jump to itself ends the program.
  endtask

  task automatic model_write(input reg_idx_t dest, input word_t val);
    if (dest != '0) begin
      mdl_regs[dest] = val;
      exp_dest.push_back(dest);
      exp_wdata.push_back(val);
    end
  endtask

  task automatic run_model();
    word_t    pc;
    word_t    next_pc;
    word_t    instr;
    word_t    simm;
    word_t    a;
    word_t    b;
    word_t    addr;
    reg_idx_t rt;
    int       steps;
    logic     halted;
    for (int i = 0; i < NUM_REGS; i++) begin
      mdl_regs[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mdl_mem[i] = fill_word(i);
    end
    pc = RESET_PC;
    halted = 1'b0;
    steps = 0;
    while (!halted && steps < MODEL_STEPS) begin
      instr = imem[pc[9:2]];
      rt = instr[20:16];
      simm = {{16{instr[15]}}, instr[15:0]};
      a = mdl_regs[instr[25:21]];
      b = mdl_regs[rt];
      addr = a + simm;
      next_pc = pc + 32'd4;
      case (opcode_e'(instr[31:26]))
        R_TYPE: begin
          case (funct_e'(instr[5:0]))
            ADD:     model_write(instr[15:11], a + b);
            SUB:     model_write(instr[15:11], a - b);
            AND:     model_write(instr[15:11], a & b);
            OR:      model_write(instr[15:11], a | b);
            SLT:     model_write(instr[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            default: ;
          endcase
        end
        ADDI: model_write(rt, addr);
        LW:   model_write(rt, mdl_mem[addr[9:2]]);
        SW: begin
          exp_saddr.push_back(addr);
          exp_sdata.push_back(b);
          mdl_mem[addr[9:2]] = b;
        end
        BEQ: begin
          if (a == b) begin
            next_pc = pc + 32'd4 + {simm[29:0], 2'b00};
          end
        end
        J: begin
          next_pc = {next_pc[31:28], instr[25:0], 2'b00};
          halted = (next_pc == pc);
        end
        default: ;
      endcase
      pc = next_pc;
      steps++;
    end
    if (!halted) begin
      errors++;
      $display("reference model ran %0d steps without reaching the halt jump", steps);
    end
  endtask

  task automatic check_reg_write(input reg_idx_t dest, input word_t data);
    reg_idx_t want_dest;
    word_t    want_data;
    checks++;
    if (exp_dest.size() == 0) begin
      errors++;
      $display("unexpected register write r%0d = %h at %0t ns", dest, data, $time);
    end else begin
      want_dest = exp_dest.pop_front();
      want_data = exp_wdata.pop_front();
      if (dest !== want_dest || data !== want_data) begin
        errors++;
        $display("[FAIL] %0t ns: write r%0d = %h, expected r%0d = %h", $time, dest, data,
                 want_dest, want_data);
      end
    end
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    word_t want_addr;
    word_t want_data;
    checks++;
    if (exp_saddr.size() == 0) begin
      errors++;
      $display("unexpected store of %h to %h at %0t ns", data, addr, $time);
    end else begin
      want_addr = exp_saddr.pop_front();
      want_data = exp_sdata.pop_front();
      if (addr !== want_addr || data !== want_data) begin
        errors++;
        $display("[FAIL] %0t ns: store %h to %h, expected %h to %h", $time, data, addr,
                 want_data, want_addr);
      end
    end
  endtask

  // outputs come from stage registers, so they are settled at the falling edge.
  always @(negedge clk) begin
    if (armed && wb_valid) begin
      check_reg_write(wb_dest, wb_data);
    end
    if (armed && dmem_we) begin
      check_store(dmem_addr, dmem_wdata);
    end
  end

  task automatic run_program(input string name);
    int err_before;
    int chk_before;
    err_before = errors;
    chk_before = checks;
    armed = 1'b0;
    exp_dest.delete();
    exp_wdata.delete();
    exp_saddr.delete();
    exp_sdata.delete();
    @(posedge clk);
    #1 arst_n = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0;
    end
    foreach (prog[i]) begin
      imem[IMEM_BASE + i] = prog[i];
    end
    run_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
    armed = 1'b1;
    while (exp_dest.size() != 0 || exp_saddr.size() != 0) begin
      @(negedge clk);
    end
    repeat (DRAIN_CYCLES) @(negedge clk); // anything retiring now is a duplicate or a leak.
    #1 armed = 1'b0;
    tests++;
    if (errors == err_before) begin
      $display("test %s passed with %0d checks", name, checks - chk_before);
    end else begin
      $display("test %s failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic test_alu_chain();
    prog.delete();
    emit(enc_i(ADDI, 1, 0, 16'd7));
    emit(enc_i(ADDI, 2, 0, 16'hfffd));
    emit(enc_r(ADD, 3, 1, 2)); // r2 from MEM, r1 from WB.
    emit(enc_r(SUB, 4, 3, 1));
    emit(enc_r(AND, 5, 4, 3));
    emit(enc_r(OR, 6, 5, 2));
    emit(enc_r(SLT, 7, 6, 5));
    emit(enc_r(SLT, 8, 5, 2));
    emit(enc_i(ADDI, 9, 8, 16'd100));
    emit(enc_r(ADD, 9, 9, 9));
    emit_halt();
    run_program("alu_chain");
  endtask

  task automatic test_load_use();
    prog.delete();
    emit(enc_i(ADDI, 1, 0, 16'd64));
    emit(enc_i(LW, 2, 1, 16'd0));
    emit(enc_r(ADD, 3, 2, 2));
    emit(enc_i(LW, 4, 1, 16'd4));
    emit(enc_i(SW, 4, 1, 16'd8)); // the loaded value is the store data.
    emit(enc_i(LW, 5, 1, 16'd8));
    emit(enc_i(ADDI, 6, 5, 16'd1));
    emit_halt();
    run_program("load_use");
  endtask

  task automatic test_stores();
    prog.delete();
    emit(enc_i(ADDI, 1, 0, 16'd16));
    emit(enc_i(ADDI, 2, 0, 16'h0055));
    emit(enc_i(SW, 2, 1, 16'd0));
    emit(enc_i(ADDI, 2, 2, 16'd1));
    emit(enc_i(SW, 2, 1, 16'd4));
    emit(enc_i(SW, 1, 1, 16'hfffc));
    emit(enc_r(ADD, 3, 1, 2));
    emit(enc_i(SW, 3, 1, 16'd8));
    emit(enc_i(LW, 4, 1, 16'd4));
    emit_halt();
    run_program("stores");
  endtask

  task automatic test_branches();
    prog.delete();
    emit(enc_i(ADDI, 1, 0, 16'd5));
    emit(enc_i(ADDI, 2, 0, 16'd5));
    emit(enc_i(BEQ, 2, 1, 16'd2)); // taken, lands on index 5.
    emit(enc_i(ADDI, 3, 0, 16'd111));
    emit(enc_i(ADDI, 4, 0, 16'd222));
    emit(enc_i(ADDI, 5, 0, 16'd1));
    emit(enc_i(BEQ, 5, 1, 16'd1));
    emit(enc_i(ADDI, 6, 0, 16'd2));
    emit(enc_j(instr_addr(11)));
    emit(enc_i(SW, 1, 0, 16'd0));
    emit(enc_i(ADDI, 7, 0, 16'd333));
    emit(enc_i(ADDI, 8, 0, 16'd3));
    emit_halt();
    run_program("branches");
  endtask

  task automatic test_r0();
    prog.delete();
    emit(enc_i(ADDI, 0, 0, 16'd9));
    emit(enc_r(ADD, 1, 0, 0));
    emit(enc_i(ADDI, 0, 1, 16'd4));
    emit(enc_r(OR, 2, 0, 1));
    emit(enc_i(LW, 0, 0, 16'd0));
    emit(enc_r(ADD, 3, 0, 0));
    emit(enc_r(SUB, 4, 3, 0));
    emit_halt();
    run_program("r0");
  endtask

  task automatic test_random(input int n);
    word_t    rnd;
    funct_e   f;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    prog.delete();
    for (int r = 1; r < 8; r++) begin
      rnd = lcg_next();
      emit(enc_i(ADDI, reg_idx_t'(r), 0, rnd[31:16]));
    end
    for (int k = 0; k < RAND_OPS; k++) begin
      rnd = lcg_next();
      rd = {2'b00, rnd[28:26]};
      rs = {2'b00, rnd[25:23]};
      rt = {2'b00, rnd[22:20]};
      case (rnd[31:29])
        3'd0, 3'd5: f = ADD;
        3'd1, 3'd6: f = SUB;
        3'd2:       f = AND;
        3'd3:       f = OR;
        default:    f = SLT;
      endcase
      if (rnd[31:29] == 3'd7) begin
        emit(enc_i(ADDI, rd, rs, rnd[15:0]));
      end else begin
        emit(enc_r(f, rd, rs, rt));
      end
    end
    emit_halt();
    run_program($sformatf("random_%0d", n));
  endtask

  initial begin
    arst_n = 1'b0;
    armed = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    lcg_state = LCG_SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0;
    end
    test_alu_chain();
    test_load_use();
    test_stores();
    test_branches();
    test_r0();
    for (int n = 0; n < RAND_PROGS; n++) begin
      test_random(n);
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic     clk,
  input  logic     arst_n,
  output word_t    imem_addr,
  input  word_t    imem_rdata,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  output logic     dmem_we,
  input  word_t    dmem_rdata,
  output logic     wb_valid,
  output reg_idx_t wb_dest,
  output word_t    wb_data
);

  hazard_if hz ();

  word_t   f_pc;
  word_t   target;
  if_id_t  if_id_d;
  if_id_t  if_id_q;
  logic    if_id_valid;
  id_ex_t  id_ex_d;
  id_ex_t  id_ex_q;
  logic    id_ex_valid;
  ex_mem_t ex_mem_d;
  ex_mem_t ex_mem_q;
  logic    ex_mem_valid;
  mem_wb_t mem_wb_d;
  mem_wb_t mem_wb_q;
  logic    mem_wb_valid;

  assign if_id_d.pc    = f_pc;
  assign if_id_d.instr = imem_rdata;

  // load-use check looks at what currently sits in EX.
  assign hz.e_dest     = id_ex_q.dest;
  assign hz.e_mem_read = id_ex_q.mem_read && id_ex_valid;

  assign mem_wb_d.result    = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_result;
  assign mem_wb_d.dest      = ex_mem_q.dest;
  assign mem_wb_d.reg_write = ex_mem_q.reg_write;

  assign dmem_addr  = ex_mem_q.alu_result;
  assign dmem_wdata = ex_mem_q.store_data;
  assign dmem_we    = ex_mem_q.mem_write && ex_mem_valid;

  assign wb_valid = mem_wb_valid && mem_wb_q.reg_write && mem_wb_q.dest != '0;
  assign wb_dest  = mem_wb_q.dest;
  assign wb_data  = mem_wb_q.result;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .arst_n(arst_n), .hz(hz), .target(target),
    .imem_addr(imem_addr), .f_pc(f_pc)
  );

  pipe_stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .arst_n(arst_n), .stall(hz.stall_d), .flush(hz.flush_d),
    .d(if_id_d), .d_valid(1'b1), .q(if_id_q), .q_valid(if_id_valid)
  );

  decode_stage u_decode (
    .clk(clk), .arst_n(arst_n), .hz(hz), .in_id(if_id_q),
    .wb(mem_wb_q), .wb_valid_in(wb_valid), .out_ex(id_ex_d)
  );

  pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(hz.flush_e),
    .d(id_ex_d), .d_valid(if_id_valid), .q(id_ex_q), .q_valid(id_ex_valid)
  );

  execute_stage u_execute (
    .hz(hz), .in_ex(id_ex_q), .in_valid(id_ex_valid),
    .mem_fwd(ex_mem_q.alu_result), .wb_fwd(mem_wb_q.result),
    .out_mem(ex_mem_d), .target(target)
  );

  hazard_unit u_hazard (
    .hz(hz), .ex_rs(id_ex_q.rs), .ex_rt(id_ex_q.rt),
    .mem_dest(ex_mem_q.dest), .wb_dest(mem_wb_q.dest),
    .mem_reg_write(ex_mem_q.reg_write && ex_mem_valid), .wb_reg_write(wb_valid)
  );

  pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(1'b0),
    .d(ex_mem_d), .d_valid(id_ex_valid), .q(ex_mem_q), .q_valid(ex_mem_valid)
  );

  pipe_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(1'b0),
    .d(mem_wb_d), .d_valid(ex_mem_valid), .q(mem_wb_q), .q_valid(mem_wb_valid)
  );

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  hazard_if.decode_mp hz,
  input  if_id_t  in_id,
  input  mem_wb_t wb,
  input  logic    wb_valid_in,
  output id_ex_t  out_ex
);

  word_t    regs [NUM_REGS];
  opcode_e  opcode;
  funct_e   funct;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    pc_plus4;

  function automatic word_t rf_read(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_valid_in && wb.dest == idx) begin
      return wb.result; // same-cycle write is seen by the read.
    end
    return regs[idx];
  endfunction

  assign opcode   = opcode_e'(in_id.instr[31:26]);
  assign funct    = funct_e'(in_id.instr[5:0]);
  assign rs       = in_id.instr[25:21];
  assign rt       = in_id.instr[20:16];
  assign rd       = in_id.instr[15:11];
  assign pc_plus4 = in_id.pc + 32'd4;
  assign hz.d_rs  = rs;
  assign hz.d_rt  = rt;

  always_comb begin
    out_ex             = '0;
    out_ex.pc          = in_id.pc;
    out_ex.rs          = rs;
    out_ex.rt          = rt;
    out_ex.rs_val      = rf_read(rs);
    out_ex.rt_val      = rf_read(rt);
    out_ex.imm         = {{(XLEN-IMM_W){in_id.instr[IMM_W-1]}}, in_id.instr[IMM_W-1:0]};
    out_ex.jump_target = {pc_plus4[XLEN-1:JADDR_W+2], in_id.instr[JADDR_W-1:0], 2'b00};
    out_ex.alu_op      = ALU_ADD;
    out_ex.dest        = rt;
    case (opcode)
      R_TYPE: begin
        out_ex.dest      = rd;
        out_ex.reg_write = 1'b1;
        case (funct)
          ADD:     out_ex.alu_op = ALU_ADD;
          SUB:     out_ex.alu_op = ALU_SUB;
          AND:     out_ex.alu_op = ALU_AND;
          OR:      out_ex.alu_op = ALU_OR;
          SLT:     out_ex.alu_op = ALU_SLT;
          default: out_ex.reg_write = 1'b0; // unsupported function retires as a no-op.
        endcase
      end
      ADDI: begin
        out_ex.alu_src_imm = 1'b1;
        out_ex.reg_write   = 1'b1;
      end
      LW: begin
        out_ex.alu_src_imm = 1'b1;
        out_ex.mem_read    = 1'b1;
        out_ex.reg_write   = 1'b1;
      end
      SW: begin
        out_ex.alu_src_imm = 1'b1;
        out_ex.mem_write   = 1'b1;
      end
      BEQ:     out_ex.is_branch = 1'b1;
      J:       out_ex.is_jump   = 1'b1;
      default: out_ex.dest      = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wb_valid_in) begin
      regs[wb.dest] <= wb.result;
    end
  end

  // write-back strips r0 destinations before the register file sees them.
  a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid_in |-> wb.dest != '0);

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage
  import isa_pkg::*, pipe_pkg::*;
(
  hazard_if.execute_mp hz,
  input  id_ex_t  in_ex,
  input  logic    in_valid,
  input  word_t   mem_fwd,
  input  word_t   wb_fwd,
  output ex_mem_t out_mem,
  output word_t   target
);

  word_t op_a;
  word_t rt_fwd;
  word_t op_b;
  word_t alu_result;
  word_t branch_target;
  logic  taken;

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign op_a   = fwd_mux(hz.fwd_a, in_ex.rs_val, mem_fwd, wb_fwd);
  assign rt_fwd = fwd_mux(hz.fwd_b, in_ex.rt_val, mem_fwd, wb_fwd);
  assign op_b   = in_ex.alu_src_imm ? in_ex.imm : rt_fwd;

  always_comb begin
    case (in_ex.alu_op)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_SLT: alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
      default: alu_result = op_a + op_b;
    endcase
  end

  // offset counts words from the instruction after the branch.
  assign branch_target = in_ex.pc + 32'd4 + {in_ex.imm[XLEN-3:0], 2'b00};
  assign taken         = in_ex.is_jump || (in_ex.is_branch && op_a == rt_fwd);
  assign hz.redirect   = in_valid && taken;
  assign target        = in_ex.is_jump ? in_ex.jump_target : branch_target;

  always_comb begin
    out_mem.alu_result = alu_result;
    out_mem.store_data = rt_fwd;
    out_mem.dest       = in_ex.dest;
    out_mem.mem_read   = in_ex.mem_read;
    out_mem.mem_write  = in_ex.mem_write;
    out_mem.reg_write  = in_ex.reg_write;
  end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
  import isa_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic   clk,
  input  logic   arst_n,
  hazard_if.fetch_mp hz,
  input  word_t  target,
  output word_t  imem_addr,
  output word_t  f_pc
);

  word_t pc;
  word_t pc_next;

  always_comb begin
    if (hz.redirect) begin
      pc_next = target; // a taken branch or jump wins over a load-use hold.
    end else if (hz.stall_f) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;
  assign f_pc      = pc;

endmodule

`default_nettype wire

// File: source/hazard_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hazard_if
  import isa_pkg::*, pipe_pkg::*;
();

  logic     stall_f;
  logic     stall_d;
  logic     flush_d;
  logic     flush_e;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  logic     redirect;
  reg_idx_t d_rs;
  reg_idx_t d_rt;
  reg_idx_t e_dest;     // destination of the instruction now in EX.
  logic     e_mem_read; // set when that instruction is a valid load.

  modport hazard_mp (
    input  d_rs, d_rt, e_dest, e_mem_read, redirect,
    output stall_f, stall_d, flush_d, flush_e, fwd_a, fwd_b
  );

  modport fetch_mp (input stall_f, redirect);

  modport decode_mp (output d_rs, d_rt);

  modport execute_mp (input fwd_a, fwd_b, output redirect);

endinterface

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit
  import isa_pkg::*, pipe_pkg::*;
(
  hazard_if.hazard_mp hz,
  input  reg_idx_t ex_rs,
  input  reg_idx_t ex_rt,
  input  reg_idx_t mem_dest,
  input  reg_idx_t wb_dest,
  input  logic     mem_reg_write,
  input  logic     wb_reg_write
);

  logic load_use;

  function automatic fwd_sel_e fwd_pick(input reg_idx_t src);
    if (src == '0) begin
      return FWD_NONE; // r0 is constant, nothing to forward.
    end
    if (mem_reg_write && mem_dest == src) begin
      return FWD_MEM; // the younger result wins.
    end
    if (wb_reg_write && wb_dest == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  // a load in EX cannot feed the instruction behind it in time.
  assign load_use = hz.e_mem_read && hz.e_dest != '0 &&
                    (hz.e_dest == hz.d_rs || hz.e_dest == hz.d_rt);

  assign hz.stall_f = load_use;
  assign hz.stall_d = load_use;
  assign hz.flush_d = hz.redirect;
  assign hz.flush_e = load_use || hz.redirect;

  always_comb begin
    hz.fwd_a = fwd_pick(ex_rs);
    hz.fwd_b = fwd_pick(ex_rt);
  end

endmodule

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int XLEN      = 32;
  localparam int NUM_REGS  = 32;
  localparam int REG_IDX_W = $clog2(NUM_REGS);
  localparam int IMM_W     = 16; // immediate field of I-type instructions.
  localparam int JADDR_W   = 26; // word index field of J.

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // primary opcodes in instr[31:26].
  typedef enum logic [5:0] {
    R_TYPE = 6'h00,
    J      = 6'h02,
    BEQ    = 6'h04,
    ADDI   = 6'h08,
    LW     = 6'h23,
    SW     = 6'h2b
  } opcode_e;

  // function codes in instr[5:0] when the opcode is R_TYPE.
  typedef enum logic [5:0] {
    ADD = 6'h20,
    SUB = 6'h22,
    AND = 6'h24,
    OR  = 6'h25,
    SLT = 6'h2a
  } funct_e;

endpackage

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;
  import isa_pkg::*;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm;
    alu_op_e  alu_op;
    logic     alu_src_imm;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     is_branch;
    logic     is_jump;
    word_t    jump_target;
  } id_ex_t;

  typedef struct packed {
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t dest;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
  } ex_mem_t;

  typedef struct packed {
    word_t    result;
    reg_idx_t dest;
    logic     reg_write;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: source/pipe_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  input  logic     d_valid,
  output payload_t q,
  output logic     q_valid
);

  logic capture;

  assign capture = !stall && !flush;

  always_ff @(posedge clk) begin
    if (capture) begin
      q <= d; // a bubble keeps stale payload, the valid bit marks it dead.
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q_valid <= 1'b0;
    end else if (flush) begin
      q_valid <= 1'b0;
    end else if (!stall) begin
      q_valid <= d_valid;
    end
  end

  // the hazard unit only holds and squashes a stage at once when it carries a live instruction.
  a_no_idle_hold_flush: assert property (@(posedge clk) disable iff (!arst_n)
    !(stall && flush && !q_valid));

endmodule

`default_nettype wire
